/* ahci_xmit.f */
+incdir+include
design/ahci_xmit_pkg.sv
design/chead_fetch.sv
design/fis_xmit_ctrl.sv
design/todev_out_reg.sv
design/ahci_fis_xmit.sv
verif/ahci_xmit_assertions.sv
verif/xmit_checker.sv
verif/tb_ahci_fis_xmit.sv

/* Makefile */
# Verilator build for the AHCI transmit path
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_ahci_fis_xmit
FLIST     ?= ahci_xmit.f
OBJ       ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* verif/xmit_input.dat */
# name prdtl c b r p w cfl xfer_dwords(hex) xfer_zero dma_len back_pressure err
# err bits: 1 sync escape, 2 transmit error, 4 X_RDY collision
basic_rd   0004 1 0 0 1 0 5  00000010 0 20 0 0
dma_short  0001 0 0 0 0 1 3  00000020 0 7  0 0
cfl_one    0000 0 0 0 0 0 1  00000004 0 4  0 0
cfl_max    0002 0 1 0 1 1 16 00000008 0 12 0 0
zero_cnt   0010 0 0 1 0 0 7  00000000 1 30 0 0
big_cnt    0003 1 1 1 1 1 9  00100000 0 25 0 0
cap_2048   0020 0 0 0 1 0 4  00001000 0 2100 0 0
bp_cfis    0005 0 0 0 1 0 12 0000000c 0 40 1 0
bp_dx      0006 1 0 0 0 1 2  00000040 0 50 1 0
err_sync   0001 0 0 0 0 0 5  00000020 0 30 0 1
err_xmit   0007 0 0 0 1 1 6  00000020 0 30 0 2
err_coll   0008 1 0 0 0 0 3  00000020 0 30 1 4
after_err  0000 0 0 0 1 0 4  00000006 0 10 1 0
bp_long    0009 0 1 1 0 1 10 00000080 0 90 1 0

/* verif/tb_ahci_fis_xmit.sv */
/* testbench of ahci_fis_xmit with memory, DMA and link models
   runs fetch, command FIS and data FIS for each line of verif/xmit_input.dat */
`include "ahci_xmit_cfg.svh"

module tb_ahci_fis_xmit import ahci_xmit_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 10000;

    logic mclk = 1'b0;
    logic hba_rst, fetch_cmd, cfis_xmit, dx_xmit, clearCmdToIssue;
    logic done, busy, pCmdToIssue, dma_ctba_ld, dma_start, dma_dev_wr;
    logic dma_prd_start, dma_cmd_abort, dma_re, dma_dav, last_h2d_data;
    logic todev_valid, todev_ready, xfer_cntr_zero, ch_c, ch_b, ch_r, ch_p, ch_w;
    link_status_t link;
    xmit_err_t    dx_err;
    prdtl_t       ch_prdtl;
    cfl_t         ch_cfl;
    dw_count_t    dwords_sent;
    reg_addr_t    reg_addr, reg_a1, reg_a2;
    ct_addr_t     ct_addr, ct_a1, ct_a2;
    logic [1:0]   reg_re, ct_re;
    logic         reg_v2, ct_v2;
    dword_t       reg_rdata, ct_data, dma_out;
    logic [29:0]  xfer_cntr;
    todev_word_t  todev_word;

    dword_t reg_mem [1024];
    dword_t ct_mem [32];
    dword_t dma_mem [4096];
    logic [31:0] lcg_state = 32'd3675;
    int   dma_idx, idx_n, dma_len_q, acc_cnt, acc_base;
    logic dma_load, dma_taken, last_evt, err_evt, stream_on, bp_on;
    logic [2:0] inject;  // error bits for the link model
    logic [31:0] rnd;

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    always #20 mclk = ~mclk;

    ahci_fis_xmit ahci_fis_xmit_i (.*);
    xmit_checker  xmit_checker_i (.*);

    // register memory and command table, re then regen then data
    always @(negedge mclk) begin
        if (reg_re[0]) reg_a1 <= reg_addr;
        reg_v2 <= reg_re[1];
        reg_a2 <= reg_a1;
        if (reg_v2) reg_rdata <= reg_mem[reg_a2];
        if (ct_re[0]) ct_a1 <= ct_addr;
        ct_v2 <= ct_re[1];
        ct_a2 <= ct_a1;
        if (ct_v2) ct_data <= ct_mem[ct_a2];
    end

    always @(posedge mclk) begin
        dma_taken <= dma_re;
        last_evt  <= todev_valid && todev_ready && todev_word.wtype[1];
        err_evt   <= todev_valid && todev_ready && (inject != 3'd0) && (acc_cnt - acc_base == 1);
        if (todev_valid && todev_ready) acc_cnt <= acc_cnt + 1;
    end

    // link answers, FWFT DMA source and FIFO ready
    always @(negedge mclk) begin
        link <= '0;
        if (last_evt && inject == 3'd0) link.xmit_ok <= 1'b1;
        if (err_evt) link <= {1'b0, inject[1], inject[0], inject[2]};
        idx_n = dma_load ? 0 : (dma_taken ? dma_idx + 1 : dma_idx);
        dma_idx       <= idx_n;
        dma_dav       <= idx_n < dma_len_q;
        dma_out       <= dma_mem[idx_n[11:0]];
        last_h2d_data <= idx_n == dma_len_q - 1;
        if (stream_on && bp_on) begin
            rnd = lcg_rand();
            todev_ready <= rnd[16];
        end else begin
            todev_ready <= 1'b1;
        end
    end

    task automatic pulse_cmd(input int which);
        @(negedge mclk);
        case (which)
            0: fetch_cmd <= 1'b1;
            1: cfis_xmit <= 1'b1;
            2: dx_xmit <= 1'b1;
            default: clearCmdToIssue <= 1'b1;
        endcase
        @(negedge mclk);
        fetch_cmd       <= 1'b0;
        cfis_xmit       <= 1'b0;
        dx_xmit         <= 1'b0;
        clearCmdToIssue <= 1'b0;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge mclk);
            n++;
        end
        if (!done) xmit_checker_i.report_fail({what, " never signalled done"});
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge mclk);
            n++;
        end
        if (busy) xmit_checker_i.report_fail("busy stuck high");
    endtask

    task automatic run_test(input string name, input prdtl_t prdtl, input logic [4:0] hbits,
                            input cfl_t cfl, input logic [29:0] xfer, input logic xzero,
                            input int len, input logic bp, input logic [2:0] err);
        dword_t      hdr;
        int          lim, exp_dx;
        int          prd_base, prd_exp;
        todev_word_t w;
        xmit_checker_i.cur_name = name;
        hdr = {prdtl, 5'b0, hbits, 1'b0, cfl};  // hbits is {c, b, r, p, w}
        for (int a = 0; a < 1024; a++) reg_mem[a] = lcg_rand() ^ {a[9:0], 12'h0, a[9:0]};
        for (int a = 0; a < 32; a++) ct_mem[a] = lcg_rand() + 32'(a);
        for (int a = 0; a < 4096; a++) dma_mem[a] = lcg_rand() ^ 32'(a);
        reg_mem[`AHCI_CLB_OFFS] = hdr;
        reg_mem[`AHCI_CLB_OFFS + 1] = 32'h0;  // PRDBC
        // fetch, fixed latency
        wait_idle();
        prd_base = xmit_checker_i.prd_cnt;
        prd_exp  = (hbits[1] || !hbits[0]) ? 1 : 0;  // P set or W clear starts PRDs early
        pulse_cmd(0);
        wait_done("fetch");
        @(negedge mclk);  // done cycle is recorded at its closing edge
        xmit_checker_i.check_val("ctba_ld cycle", 5,
                                 xmit_checker_i.ctba_at - xmit_checker_i.fetch_at);
        xmit_checker_i.check_val("start cycle", 6,
                                 xmit_checker_i.start_at - xmit_checker_i.fetch_at);
        xmit_checker_i.check_val("done cycle", 7,
                                 xmit_checker_i.done_at - xmit_checker_i.fetch_at);
        xmit_checker_i.check_val("header fields", {prdtl, hbits, cfl},
                                 {ch_prdtl, ch_c, ch_b, ch_r, ch_p, ch_w, ch_cfl});
        xmit_checker_i.check_val("dma_dev_wr", hbits[0], dma_dev_wr);
        xmit_checker_i.check_val("prd_start at fetch", prd_exp,
                                 xmit_checker_i.prd_cnt - prd_base);
        xmit_checker_i.check_val("pCmdToIssue set", 1, pCmdToIssue);
        pulse_cmd(3);
        xmit_checker_i.check_val("pCmdToIssue cleared", 0, pCmdToIssue);
        // command FIS
        wait_idle();
        xmit_checker_i.clear_expect();
        xmit_checker_i.ignore_words = 1'b0;
        for (int i = 0; i < int'(cfl); i++) begin
            w.data  = ct_mem[i];
            w.wtype = {i == int'(cfl) - 1, i == 0};
            xmit_checker_i.push_word(w);
        end
        bp_on = bp;
        stream_on = 1'b1;
        pulse_cmd(1);
        xmit_checker_i.check_val("busy after cfis_xmit", 1, busy);
        wait_done("cfis_xmit");
        xmit_checker_i.check_val("cfis dx_err", 0, dx_err);
        xmit_checker_i.check_val("cfis words left", 0, xmit_checker_i.exp_q.size());
        // data FIS, limit is the smaller of capped count and DMA length
        wait_idle();
        lim = xzero ? 2048 : ((xfer > 30'd2048) ? 2048 : int'(xfer));
        exp_dx = (lim < len) ? lim : len;
        w.data  = `AHCI_DATA_FIS;
        w.wtype = 2'b01;
        xmit_checker_i.push_word(w);
        for (int i = 0; i < exp_dx; i++) begin
            w.data  = dma_mem[i];
            w.wtype = {i == exp_dx - 1, 1'b0};
            xmit_checker_i.push_word(w);
        end
        xfer_cntr      <= xfer;
        xfer_cntr_zero <= xzero;
        dma_len_q      <= len;
        dma_load       <= 1'b1;
        @(negedge mclk);
        dma_load <= 1'b0;
        @(negedge mclk);
        acc_base = acc_cnt;
        inject = err;
        xmit_checker_i.ignore_words = (err != 3'd0);
        pulse_cmd(2);
        xmit_checker_i.check_val("busy after dx_xmit", 1, busy);
        wait_done("dx_xmit");
        // one more PRD start with the data FIS head
        xmit_checker_i.check_val("prd_start at dx head", prd_exp + 1,
                                 xmit_checker_i.prd_cnt - prd_base);
        if (err != 3'd0) begin
            xmit_checker_i.check_val("abort with done", 1, dma_cmd_abort);
            xmit_checker_i.check_val("dx_err bits", err, dx_err);
        end else begin
            xmit_checker_i.check_val("dx words left", 0, xmit_checker_i.exp_q.size());
            xmit_checker_i.check_val("dwords_sent", exp_dx, dwords_sent);
        end
        wait_idle();
        stream_on = 1'b0;
        inject = 3'd0;
        repeat (4) @(negedge mclk);  // lets a stalled word drain
    endtask

    initial begin
        int          fd, r;
        string       line, name;
        logic [15:0] prdtl;
        int          c, b, rs, p, wr, cfl, xzero, len, bp, err;
        logic [29:0] xfer;
        hba_rst <= 1'b1;
        {fetch_cmd, cfis_xmit, dx_xmit, clearCmdToIssue} <= 4'b0;
        link <= '0;
        {reg_rdata, ct_data, dma_out} <= '0;
        {xfer_cntr, xfer_cntr_zero, dma_dav, last_h2d_data, todev_ready} <= '0;
        {dma_idx, dma_len_q, acc_cnt} <= '0;
        {dma_load, dma_taken, last_evt, err_evt} <= '0;
        acc_base = 0;
        {stream_on, bp_on, inject} = '0;
        repeat (10) @(posedge mclk);
        @(negedge mclk);
        hba_rst <= 1'b0;
        fd = $fopen("verif/xmit_input.dat", "r");
        if (fd == 0) xmit_checker_i.report_fail("cannot open verif/xmit_input.dat");
        while (fd != 0 && !$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 1 && line.getc(0) != "#") begin
                r = $sscanf(line, "%s %h %d %d %d %d %d %d %h %d %d %d %d", name, prdtl,
                            c, b, rs, p, wr, cfl, xfer, xzero, len, bp, err);
                if (r == 13) begin
                    run_test(name, prdtl, {c[0], b[0], rs[0], p[0], wr[0]}, cfl[4:0], xfer,
                             xzero[0], len, bp[0], err[2:0]);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        $display("check errors %0d, other errors %0d", xmit_checker_i.check_errs,
                 xmit_checker_i.other_errs);
        if (xmit_checker_i.check_errs == 0 && xmit_checker_i.other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verif/xmit_checker.sv */
/* scoreboard for the transmit path
   compares device FIFO words against the queue the testbench fills, counts errors */
module xmit_checker import ahci_xmit_pkg::*; (
    input logic        mclk,
    input logic        hba_rst,
    input logic        fetch_cmd,
    input logic        dma_ctba_ld,
    input logic        dma_start,
    input logic        dma_prd_start,
    input logic        done,
    input todev_word_t todev_word,
    input logic        todev_valid,
    input logic        todev_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    todev_word_t exp_q [$];      // words still owed by the DUT
    int          check_errs = 0;
    int          other_errs = 0;
    int          cyc = 0;        // posedge count
    int          fetch_at = 0;
    int          ctba_at = 0;
    int          start_at = 0;
    int          done_at = 0;
    int          prd_cnt = 0;    // dma_prd_start pulses seen so far
    string       cur_name = "none";
    logic        ignore_words = 1'b0;  // stream after a link error is not compared

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %0s %0s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        other_errs++;
        $display("ERROR in %0s: %0s", cur_name, msg);
    endtask

    task automatic push_word(input todev_word_t w);
        exp_q.push_back(w);
    endtask

    task automatic clear_expect();
        exp_q.delete();
    endtask

    task automatic compare_word(input todev_word_t w);
        todev_word_t e;
        if (exp_q.size() == 0) begin
            report_fail("device FIFO got a word that was not expected");
        end else begin
            e = exp_q.pop_front();
            check_val("word data", e.data, w.data);
            check_val("word type", 32'(e.wtype), 32'(w.wtype));
        end
    endtask

    always @(posedge mclk) begin
        cyc <= cyc + 1;
        if (fetch_cmd) fetch_at <= cyc;      // cycle t
        if (dma_ctba_ld) ctba_at <= cyc;
        if (dma_start) start_at <= cyc;
        if (done) done_at <= cyc;
        if (!hba_rst && dma_prd_start) prd_cnt <= prd_cnt + 1;
        if (!hba_rst && todev_valid && todev_ready && !ignore_words) begin
            compare_word(todev_word);  // one accepted word per cycle at most
        end
    end

endmodule

/* verif/ahci_xmit_assertions.sv */
/* protocol rules of the transmit top level
   attached to ahci_fis_xmit by the bind at the end of this file */
module ahci_xmit_assertions import ahci_xmit_pkg::*; (
    input logic        mclk,
    input logic        hba_rst,
    input logic        done,
    input logic        busy,
    input logic        pCmdToIssue,
    input logic        dma_ctba_ld,
    input logic        dma_start,
    input logic        dma_prd_start,
    input logic        dma_cmd_abort,
    input logic        dma_re,
    input logic [1:0]  reg_re,
    input logic [1:0]  ct_re,
    input todev_word_t todev_word,
    input logic        todev_valid,
    input logic        todev_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    done_pulse: assert property (@(posedge mclk) disable iff (hba_rst) done |=> !done)
        else $error("done held for more than one cycle");

    // DMA command strobes
    ctba_pulse: assert property (@(posedge mclk) disable iff (hba_rst)
        dma_ctba_ld |=> !dma_ctba_ld) else $error("dma_ctba_ld is not a single pulse");
    start_pulse: assert property (@(posedge mclk) disable iff (hba_rst)
        dma_start |=> !dma_start) else $error("dma_start is not a single pulse");

    // stalled word must wait untouched
    word_hold: assert property (@(posedge mclk) disable iff (hba_rst)
        todev_valid && !todev_ready |=> todev_valid && $stable(todev_word))
        else $error("todev_word changed while stalled");

    quiet_reset: assert property (@(posedge mclk) hba_rst && $past(hba_rst) |->
        !(done || busy || pCmdToIssue || dma_ctba_ld || dma_start || dma_prd_start ||
          dma_cmd_abort || todev_valid || dma_re || (|reg_re) || (|ct_re)))
        else $error("control output active during reset");

endmodule

bind ahci_fis_xmit ahci_xmit_assertions ahci_xmit_assertions_i (.*);

/* design/ahci_fis_xmit.sv */
/* transmit side of an AHCI host port
   command header fetch, command FIS and data FIS toward the device FIFO */
module ahci_fis_xmit import ahci_xmit_pkg::*; (
    input  logic         mclk,
    input  logic         hba_rst,
    // command strobes
    input  logic         fetch_cmd,
    input  logic         cfis_xmit,
    input  logic         dx_xmit,
    input  logic         clearCmdToIssue,
    output logic         done,
    output logic         busy,
    output logic         pCmdToIssue,
    // link layer
    input  link_status_t link,
    output xmit_err_t    dx_err,
    // decoded command header
    output prdtl_t       ch_prdtl,
    output logic         ch_c,
    output logic         ch_b,
    output logic         ch_r,
    output logic         ch_p,
    output logic         ch_w,
    output cfl_t         ch_cfl,
    output dw_count_t    dwords_sent,
    // register memory
    output reg_addr_t    reg_addr,
    output logic [1:0]   reg_re,
    input  dword_t       reg_rdata,
    // transfer counter from the receive side
    input  logic [29:0]  xfer_cntr,
    input  logic         xfer_cntr_zero,
    // DMA engine
    output logic         dma_ctba_ld,
    output logic         dma_start,
    output logic         dma_dev_wr,
    output logic         dma_prd_start,
    output logic         dma_cmd_abort,
    output ct_addr_t     ct_addr,
    output logic [1:0]   ct_re,
    input  dword_t       ct_data,
    input  dword_t       dma_out,
    input  logic         dma_dav,
    output logic         dma_re,
    input  logic         last_h2d_data,
    // device FIFO
    output todev_word_t  todev_word,
    output logic         todev_valid,
    input  logic         todev_ready
);

    chead_t      chead;
    logic        out_room;
    logic        out_load;
    todev_word_t out_word;

    assign ch_prdtl   = chead.prdtl;
    assign ch_c       = chead.c;
    assign ch_b       = chead.b;
    assign ch_r       = chead.r;
    assign ch_p       = chead.p;
    assign ch_w       = chead.w;
    assign ch_cfl     = chead.cfl;
    assign dma_dev_wr = chead.w; // memory to device

    chead_fetch chead_fetch_i (
        .mclk            (mclk),
        .hba_rst         (hba_rst),
        .fetch_cmd       (fetch_cmd),
        .clearCmdToIssue (clearCmdToIssue),
        .reg_addr        (reg_addr),
        .reg_re          (reg_re),
        .reg_rdata       (reg_rdata),
        .chead           (chead),
        .dma_ctba_ld     (dma_ctba_ld),
        .dma_start       (dma_start),
        .pCmdToIssue     (pCmdToIssue)
    );

    fis_xmit_ctrl fis_xmit_ctrl_i (
        .mclk           (mclk),
        .hba_rst        (hba_rst),
        .cfis_xmit      (cfis_xmit),
        .dx_xmit        (dx_xmit),
        .dma_start      (dma_start),
        .chead          (chead),
        .ct_addr        (ct_addr),
        .ct_re          (ct_re),
        .ct_data        (ct_data),
        .dma_out        (dma_out),
        .dma_dav        (dma_dav),
        .last_h2d_data  (last_h2d_data),
        .dma_re         (dma_re),
        .xfer_cntr      (xfer_cntr),
        .xfer_cntr_zero (xfer_cntr_zero),
        .link           (link),
        .out_room       (out_room),
        .out_load       (out_load),
        .out_word       (out_word),
        .done           (done),
        .busy           (busy),
        .dma_prd_start  (dma_prd_start),
        .dma_cmd_abort  (dma_cmd_abort),
        .dx_err         (dx_err),
        .dwords_sent    (dwords_sent)
    );

    todev_out_reg todev_out_reg_i (
        .mclk        (mclk),
        .hba_rst     (hba_rst),
        .load        (out_load),
        .word_in     (out_word),
        .room        (out_room),
        .todev_word  (todev_word),
        .todev_valid (todev_valid),
        .todev_ready (todev_ready)
    );

endmodule

/* design/todev_out_reg.sv */
/* one-entry output register toward the device FIFO
   loaded by the sequencer, emptied by the FIFO valid/ready handshake */
module todev_out_reg import ahci_xmit_pkg::*; (
    input  logic        mclk,
    input  logic        hba_rst,
    input  logic        load,        // only given while room is high
    input  todev_word_t word_in,
    output logic        room,
    output todev_word_t todev_word,
    output logic        todev_valid,
    input  logic        todev_ready
);

    logic taken;  // FIFO takes the held word this cycle

    assign taken = todev_valid && todev_ready;
    assign room  = !todev_valid || todev_ready; // empty, or emptied at this edge

    // full flag, a load wins over a take so back to back words stream
    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            todev_valid <= 1'b0;
        end else if (load) begin
            todev_valid <= 1'b1;
        end else if (taken) begin
            todev_valid <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            todev_word <= '0;
        end else if (load) begin
            todev_word <= word_in; // held while the FIFO stalls
        end
    end

endmodule

/* design/fis_xmit_ctrl.sv */
/* transmit sequencer for command FIS and data FIS
   feeds the output register and reports done, busy and link errors */
`include "ahci_xmit_cfg.svh"

module fis_xmit_ctrl import ahci_xmit_pkg::*; (
    input  logic         mclk,
    input  logic         hba_rst,
    input  logic         cfis_xmit,
    input  logic         dx_xmit,
    input  logic         dma_start,
    input  chead_t       chead,
    output ct_addr_t     ct_addr,
    output logic [1:0]   ct_re,          // [0] re, [1] regen
    input  dword_t       ct_data,
    input  dword_t       dma_out,
    input  logic         dma_dav,
    input  logic         last_h2d_data,
    output logic         dma_re,
    input  logic [29:0]  xfer_cntr,      // byte count bits [31:2]
    input  logic         xfer_cntr_zero,
    input  link_status_t link,
    input  logic         out_room,
    output logic         out_load,
    output todev_word_t  out_word,
    output logic         done,
    output logic         busy,
    output logic         dma_prd_start,
    output logic         dma_cmd_abort,
    output xmit_err_t    dx_err,
    output dw_count_t    dwords_sent
);

    xmit_state_e              state;
    xmit_err_t                err_q;
    cfl_t                     rd_left;   // ct reads still to issue
    cfl_t                     out_left;  // ct words still to hand out
    logic                     cfis_first;
    logic [`AHCI_CT_RD_LAT:0] ct_pipe;
    logic [2:0]               pend_cnt;  // reads in flight plus buffered words
    dword_t                   cbuf [4];  // catches ct words while the output stalls
    logic [2:0]               wr_ptr;
    logic [2:0]               rd_ptr;
    dw_count_t                dx_left;
    logic                     run;
    logic                     ct_issue;
    logic                     cbuf_pop;
    logic                     head_load;
    logic                     dx_last;
    logic                     ok_end;
    logic                     err_end;
    logic                     done_w;
    logic                     cmd_start;

    assign cmd_start = cfis_xmit || dx_xmit;
    assign run       = (err_q == '0);
    assign ct_issue  = run && (state == CFIS_RD) && (rd_left != '0) && (pend_cnt != 3'd4);
    assign cbuf_pop  = run && (state == CFIS_RD) && (wr_ptr != rd_ptr) && out_room;
    assign head_load = run && (state == DX_HEAD) && out_room;
    assign dma_re    = run && (state == DX_DATA) && dma_dav && out_room; // dma_out is FWFT
    assign dx_last   = (dx_left == 12'd1) || last_h2d_data;
    assign ok_end    = (state == WAIT_OK) && link.xmit_ok;
    assign err_end   = !run && (state != IDLE);
    assign done_w    = ok_end || err_end || dma_start; // dma_start ends a fetch
    assign ct_re     = ct_pipe[1:0];
    assign out_load  = cbuf_pop || head_load || dma_re;
    assign dx_err    = err_q;

    always_comb begin
        if (state == DX_DATA) begin
            out_word.data  = dma_out;
            out_word.wtype = {dx_last, 1'b0};
        end else if (state == DX_HEAD) begin
            out_word.data  = `AHCI_DATA_FIS;
            out_word.wtype = 2'b01;
        end else begin
            out_word.data  = cbuf[rd_ptr[1:0]];
            out_word.wtype = {(out_left == 5'd1), cfis_first}; // cfl 1 gives head and last
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || err_end) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cfis_xmit) begin
                        state <= CFIS_RD;
                    end else if (dx_xmit) begin
                        state <= DX_HEAD;
                    end
                end
                CFIS_RD: if ((out_left == '0) || (cbuf_pop && (out_left == 5'd1))) state <= WAIT_OK;
                DX_HEAD: if (head_load) state <= DX_DATA;
                DX_DATA: if (dma_re && dx_last) state <= WAIT_OK;
                WAIT_OK: if (link.xmit_ok) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // errors stay until the next command
    always_ff @(posedge mclk) begin
        if (hba_rst || cmd_start) begin
            err_q <= '0;
        end else begin
            err_q <= err_q | {link.xrdy_collision, link.xmit_err, link.syncesc_recv};
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || cfis_xmit) begin
            ct_pipe  <= '0;
            pend_cnt <= 3'd0;
            wr_ptr   <= 3'd0;
            rd_ptr   <= 3'd0;
        end else begin
            ct_pipe  <= {ct_pipe[`AHCI_CT_RD_LAT-1:0], ct_issue};
            pend_cnt <= pend_cnt + {2'b00, ct_issue} - {2'b00, cbuf_pop};
            if (ct_pipe[`AHCI_CT_RD_LAT]) wr_ptr <= wr_ptr + 3'd1;
            if (cbuf_pop) rd_ptr <= rd_ptr + 3'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (ct_pipe[`AHCI_CT_RD_LAT]) begin
            cbuf[wr_ptr[1:0]] <= ct_data;
        end
        if (cfis_xmit) begin
            ct_addr <= '0;
        end else if (ct_pipe[0]) begin
            ct_addr <= ct_addr + ct_addr_t'(1); // next dword after each re
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            rd_left    <= '0;
            out_left   <= '0;
            cfis_first <= 1'b0;
        end else if (cfis_xmit) begin
            rd_left    <= chead.cfl;
            out_left   <= chead.cfl;
            cfis_first <= 1'b1;
        end else begin
            if (ct_issue) rd_left <= rd_left - cfl_t'(1);
            if (cbuf_pop) out_left <= out_left - cfl_t'(1);
            if (cbuf_pop) cfis_first <= 1'b0;
        end
    end

    // transfer count capped at one FIS, zero counter means no limit but the cap
    always_ff @(posedge mclk) begin
        if (dx_xmit) begin
            dx_left <= (xfer_cntr_zero || (|xfer_cntr[29:11])) ? `AHCI_MAX_DX_DW
                                                               : {1'b0, xfer_cntr[10:0]};
        end else if (dma_re) begin
            dx_left <= dx_left - 12'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || dx_xmit) begin
            dwords_sent <= '0;
        end else if (dma_re) begin
            dwords_sent <= dwords_sent + 12'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            done          <= 1'b0;
            busy          <= 1'b0;
            dma_cmd_abort <= 1'b0;
            dma_prd_start <= 1'b0;
        end else begin
            done          <= done_w;
            dma_cmd_abort <= err_end;
            // device reads and prefetchable writes may start PRDs right away
            dma_prd_start <= (dma_start && (chead.p || !chead.w)) || head_load;
            if (cmd_start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0; // still high during the done cycle
            end
        end
    end

endmodule

/* design/chead_fetch.sv */
/* command header fetch: three register reads from the command list, decode of dword 0
   and the CTBA load / DMA start strobes */
`include "ahci_xmit_cfg.svh"

module chead_fetch import ahci_xmit_pkg::*; (
    input  logic       mclk,
    input  logic       hba_rst,
    input  logic       fetch_cmd,       // strobe, only while idle
    input  logic       clearCmdToIssue,
    output reg_addr_t  reg_addr,
    output logic [1:0] reg_re,          // [0] re, [1] regen
    input  dword_t     reg_rdata,
    output chead_t     chead,
    output logic       dma_ctba_ld,
    output logic       dma_start,
    output logic       pCmdToIssue
);

    logic [1:0]                issue_cnt; // reads still to issue after the strobe
    logic [`AHCI_REG_RD_LAT:0] re_pipe;   // read latency tracker
    logic [1:0]                ret_idx;   // which header dword is on reg_rdata
    logic                      re_next;
    logic                      rd_stb;

    assign re_next = fetch_cmd || (issue_cnt != 2'd0);
    assign rd_stb  = re_pipe[`AHCI_REG_RD_LAT]; // reg_rdata valid this cycle
    assign reg_re  = re_pipe[1:0];

    // the strobe itself is the first read, two more follow
    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            issue_cnt <= 2'd0;
        end else if (fetch_cmd) begin
            issue_cnt <= 2'd2;
        end else if (issue_cnt != 2'd0) begin
            issue_cnt <= issue_cnt - 2'd1;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            re_pipe <= '0;
        end else begin
            re_pipe <= {re_pipe[`AHCI_REG_RD_LAT-1:0], re_next};
        end
    end

    // address moves on after each re cycle
    always_ff @(posedge mclk) begin
        if (fetch_cmd) begin
            reg_addr <= `AHCI_CLB_OFFS;
        end else if (re_pipe[0]) begin
            reg_addr <= reg_addr + reg_addr_t'(1);
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || fetch_cmd) begin
            ret_idx <= 2'd0;
        end else if (rd_stb) begin
            ret_idx <= ret_idx + 2'd1; // 0 flags, 1 PRDBC, 2 CTBA
        end
    end

    // decode of dword 0
    always_ff @(posedge mclk) begin
        if (rd_stb && (ret_idx == 2'd0)) begin
            chead.prdtl <= reg_rdata[31:16];
            chead.c     <= reg_rdata[10];
            chead.b     <= reg_rdata[9];
            chead.r     <= reg_rdata[8];
            chead.p     <= reg_rdata[7];
            chead.w     <= reg_rdata[6];
            chead.cfl   <= reg_rdata[4:0];
        end
    end

    // ctba_ld lands while the CTBA dword is on reg_rdata
    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            dma_ctba_ld <= 1'b0;
            dma_start   <= 1'b0;
        end else begin
            dma_ctba_ld <= rd_stb && (ret_idx == 2'd1);
            dma_start   <= dma_ctba_ld; // header fields are settled by now
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            pCmdToIssue <= 1'b0;
        end else if (rd_stb && (ret_idx == 2'd1)) begin
            pCmdToIssue <= 1'b1;
        end else if (clearCmdToIssue) begin
            pCmdToIssue <= 1'b0;
        end
    end

endmodule

/* design/ahci_xmit_pkg.sv */
/* types shared by the transmit side of the AHCI port
   import into any module that passes headers, words or link status */
package ahci_xmit_pkg;

    typedef logic [31:0] dword_t;
    typedef logic [9:0]  reg_addr_t;   // register memory dword address
    typedef logic [4:0]  ct_addr_t;    // command table dword address
    typedef logic [11:0] dw_count_t;   // up to 2048 dwords
    typedef logic [15:0] prdtl_t;
    typedef logic [4:0]  cfl_t;        // command FIS length in dwords
    typedef logic [1:0]  todev_type_t; // {last, head}
    typedef logic [2:0]  xmit_err_t;   // {collision, xmit_err, sync escape}

    // fields of dword 0 of the command header
    typedef struct packed {
        prdtl_t prdtl; // PRD entries
        logic   c;     // clear busy on R_OK
        logic   b;     // BIST
        logic   r;     // reset
        logic   p;     // prefetchable
        logic   w;     // write to device
        cfl_t   cfl;
    } chead_t;

    typedef struct packed {
        dword_t      data;
        todev_type_t wtype;
    } todev_word_t;

    // link layer pulses
    typedef struct packed {
        logic xmit_ok;
        logic xmit_err;
        logic syncesc_recv;
        logic xrdy_collision;
    } link_status_t;

    typedef enum logic [2:0] {
        IDLE,
        CFIS_RD,  // reading command FIS from the command table
        DX_HEAD,  // data FIS header dword
        DX_DATA,  // forwarding DMA dwords
        WAIT_OK   // last word out, waiting for the link
    } xmit_state_e;

endpackage

/* include/ahci_xmit_cfg.svh */
/* fixed numbers of the AHCI transmit path
   include this wherever an offset, latency or FIS constant is needed */
`ifndef AHCI_XMIT_CFG_SVH
`define AHCI_XMIT_CFG_SVH

// command list starts in the upper half of the register memory
`define AHCI_CLB_OFFS   10'h200

// both memories have a re stage and a regen stage before data shows up
`define AHCI_REG_RD_LAT 2
`define AHCI_CT_RD_LAT  2

`define AHCI_DATA_FIS   32'h0000_0046  // H2D data FIS type byte, rest zero

// one data FIS never carries more than 8KB
`define AHCI_MAX_DX_DW  12'd2048

`endif
